//--- build.f
common/pipe_ctrl_pkg.sv
hazard/fwd_select.sv
hazard/hazard_unit.sv
logic/stage_regs.sv
logic/div_busy.sv
logic/pipe_ctrl_top.sv
tb/pipe_ctrl_asserts.sv
tb/pipe_ctrl_tb.sv

//--- tb/pipe_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_tb;

    import pipe_ctrl_pkg::*;

    localparam int MAX_ROWS   = 80;
    localparam int HOLD_LIMIT = 20;
    localparam int DRAIN_LIMIT = 100;

    logic        clk;
    logic        rst_n;
    inst_desc_t  fs_desc;
    logic        fetch_hold;
    logic [3:0]  ds_fwd;
    logic [3:0]  es_fwd;
    stall_code_t stall_d;
    stall_code_t stall_e;
    stage_info_t retire;
    inst_id_t    retire_id;

    // stimulus table and expected columns
    inst_desc_t rows [MAX_ROWS];
    logic [3:0] exp_ds [MAX_ROWS];
    logic [3:0] exp_es [MAX_ROWS];
    int         exp_dx [MAX_ROWS];
    int         exp_ec [MAX_ROWS];
    int         d_cnt [MAX_ROWS];
    int         e_cnt [MAX_ROWS];
    int         n_rows;
    int         n_valid;
    int         cur_row;
    int         errors;
    int         checks;
    int         retired;
    int         ret_q [$];

    // reference pipeline state
    inst_desc_t md, me, mm, mw;
    int         r_d, r_e;
    logic       d_new, e_new_m;
    int         div_cnt;
    logic       blu, dstop, mfc, sd, se, fh, dhold, div_start;

    pipe_ctrl_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fs_desc    (fs_desc),
        .fetch_hold (fetch_hold),
        .ds_fwd     (ds_fwd),
        .es_fwd     (es_fwd),
        .stall_d    (stall_d),
        .stall_e    (stall_e),
        .retire     (retire),
        .retire_id  (retire_id)
    );

    bind hazard_unit pipe_ctrl_asserts asserts_i (
        .clk        (pipe_ctrl_tb.clk),
        .rst_n      (pipe_ctrl_tb.rst_n),
        .stall_d    (stall_d),
        .stall_e    (stall_e),
        .fetch_hold (fetch_hold),
        .ds_fwd     (ds_fwd),
        .es_fwd     (es_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic inst_desc_t mk(inst_id_t id, reg_addr_t r1, reg_addr_t r2,
                                      reg_addr_t dest, logic we, logic mem,
                                      logic cp0, logic br, logic dv);
        inst_desc_t d;
        d = '{valid: 1'b1, id: id, raddr1: r1, raddr2: r2, dest: dest, gr_we: we,
              res_from_mem: mem, res_from_cp0: cp0, is_branch: br, is_div: dv};
        return d;
    endfunction

    task automatic add_row(input inst_desc_t d, input logic [3:0] ds, input logic [3:0] es,
                           input int dx, input int ec);
        rows[n_rows]   = d;
        exp_ds[n_rows] = ds;
        exp_es[n_rows] = es;
        exp_dx[n_rows] = dx;
        exp_ec[n_rows] = ec;
        if (d.valid) n_valid++;
        n_rows++;
    endtask

    task automatic build_table();
        inst_desc_t d;
        // forwarding: near, far, priority, r0, no write
        add_row(mk(8'h01, 0, 0, 1, 1, 0, 0, 0, 0), 4'b0000, 4'b0000, 0, 1);
        add_row(mk(8'h02, 1, 0, 2, 1, 0, 0, 0, 0), 4'b0100, 4'b0100, 0, 1);
        add_row(mk(8'h03, 1, 2, 3, 1, 0, 0, 0, 0), 4'b1001, 4'b1001, 0, 1);
        add_row(mk(8'h04, 3, 3, 3, 1, 0, 0, 0, 0), 4'b0101, 4'b0101, 0, 1);
        add_row(mk(8'h05, 3, 0, 4, 1, 0, 0, 0, 0), 4'b0100, 4'b0100, 0, 1);
        add_row(mk(8'h06, 0, 4, 0, 1, 0, 0, 0, 0), 4'b0001, 4'b0001, 0, 1);
        add_row(mk(8'h07, 0, 0, 5, 0, 0, 0, 0, 0), 4'b0000, 4'b0000, 0, 1);
        add_row(mk(8'h08, 5, 4, 6, 1, 0, 0, 0, 0), 4'b0000, 4'b0000, 0, 1);
        // load then branch, load then plain consumer
        add_row(mk(8'h09, 0, 0, 7, 1, 1, 0, 0, 0), 4'b0000, 4'b0000, 0, 1);
        add_row(mk(8'h0a, 7, 0, 0, 0, 0, 0, 1, 0), 4'b0100, 4'b1000, 1, 1);
        add_row(mk(8'h0b, 0, 0, 8, 1, 1, 0, 0, 0), 4'b0000, 4'b0000, 0, 1);
        add_row(mk(8'h0c, 8, 8, 9, 1, 0, 0, 0, 0), 4'b0101, 4'b0101, 0, 1);
        // divide, then divide-load with a dependent branch
        add_row(mk(8'h0d, 9, 0, 10, 1, 0, 0, 0, 1), 4'b0100, 4'b0100, 0, DIV_CYCLES);
        add_row(mk(8'h0e, 10, 9, 11, 1, 0, 0, 0, 0), 4'b0110, 4'b0100, DIV_CYCLES - 1, 1);
        add_row(mk(8'h0f, 0, 0, 12, 1, 1, 0, 0, 1), 4'b0000, 4'b0000, 0, 1);
        add_row(mk(8'h10, 12, 0, 0, 0, 0, 0, 1, 0), 4'b0100, 4'b0000, 2, 1);
        // mfc0 then consumer
        add_row(mk(8'h11, 0, 0, 13, 1, 0, 1, 0, 0), 4'b0000, 4'b0000, 0, 1);
        add_row(mk(8'h12, 13, 0, 14, 1, 0, 0, 0, 0), 4'b0100, 4'b0000, 2, 1);
        for (int i = 0; i < 4; i++) begin
            add_row('0, 4'b0000, 4'b0000, 0, 1);
        end
        // sources below 16, dests above, so nothing forwards
        for (int i = 0; i < 40; i++) begin
            d = mk(inst_id_t'(8'h20 + i), reg_addr_t'($urandom % 16),
                   reg_addr_t'($urandom % 16), reg_addr_t'(16 + $urandom % 16),
                   logic'($urandom % 2), 0, 0, 0, 0);
            add_row(d, 4'b0000, 4'b0000, 0, 1);
        end
    endtask

    task automatic check_retire();
        int r;
        if (ret_q.size() == 0) begin
            $display("an instruction retired that was never accepted");
            errors++;
        end else begin
            r = ret_q.pop_front();
            check_val("retire_id", retire_id, rows[r].id);
            check_val("retire.dest", retire.dest, rows[r].dest);
            check_val("retire.gr_we", retire.gr_we, rows[r].gr_we);
            check_val("retire.res_from_mem", retire.res_from_mem, rows[r].res_from_mem);
            check_val("retire.res_from_cp0", retire.res_from_cp0, rows[r].res_from_cp0);
            check_val("decode_extra", d_cnt[r] - 1, exp_dx[r]);
            check_val("exec_cycles", e_cnt[r], exp_ec[r]);
            retired++;
        end
    endtask

    // reference model stepped mid-cycle, where all levels are stable
    always @(negedge clk) begin
        if (rst_n) begin
            blu = md.valid && md.is_branch && me.valid && me.gr_we && me.res_from_mem
                  && (md.raddr1 == me.dest || md.raddr2 == me.dest);
            div_start = e_new_m && me.valid && me.is_div;
            dstop = div_start || (div_cnt != 0);
            mfc = (me.valid && me.res_from_cp0) || (mm.valid && mm.res_from_cp0);
            sd = blu || (!dstop && mfc);
            se = dstop && !blu;
            fh = (sd && md.valid) || se;
            check_val("stall_d", stall_d, {1'b0, sd});
            check_val("stall_e", stall_e, {1'b0, se});
            check_val("fetch_hold", fetch_hold, fh);
            if (md.valid && d_new) check_val("ds_fwd", ds_fwd, exp_ds[r_d]);
            if (md.valid) d_cnt[r_d]++;
            if (me.valid && e_new_m) check_val("es_fwd", es_fwd, exp_es[r_e]);
            if (me.valid) e_cnt[r_e]++;
            check_val("retire.valid", retire.valid, mw.valid);
            if (mw.valid && retire.valid) check_retire();

            dhold = se || (sd && md.valid);
            mw = mm;
            mm = se ? '0 : me;
            if (!se) begin
                me = sd ? '0 : md;
                r_e = sd ? -1 : r_d;
            end
            if (div_start) div_cnt = DIV_CYCLES - 2;
            else if (e_new_m) div_cnt = 0;
            else if (div_cnt != 0) div_cnt--;
            e_new_m = !se;
            d_new = !dhold;
            if (!dhold) begin
                md = fs_desc;
                r_d = cur_row;
                if (fs_desc.valid) ret_q.push_back(cur_row);
            end
        end
    end

    task automatic finish_run();
        $display("checks: %0d, errors: %0d, retired: %0d", checks, errors, retired);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic apply_row(input int i, output bit timed_out);
        int tries;
        tries = 0;
        timed_out = 1'b0;
        fs_desc = rows[i];
        cur_row = i;
        @(negedge clk);
        while (fetch_hold && tries < HOLD_LIMIT) begin
            @(negedge clk);
            tries++;
        end
        if (fetch_hold) begin
            $display("timeout: fetch_hold stayed high while presenting row %0d", i);
            errors++;
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        int tries;
        bit hung;
        void'($urandom(32'ha7412695));
        rst_n = 1'b0;
        fs_desc = '0;
        cur_row = -1;
        errors = 0;
        checks = 0;
        retired = 0;
        n_rows = 0;
        n_valid = 0;
        hung = 1'b0;
        md = '0;
        me = '0;
        mm = '0;
        mw = '0;
        r_d = -1;
        r_e = -1;
        d_new = 1'b0;
        e_new_m = 1'b0;
        div_cnt = 0;
        for (int i = 0; i < MAX_ROWS; i++) begin
            d_cnt[i] = 0;
            e_cnt[i] = 0;
        end
        build_table();
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        // idle after reset
        @(negedge clk);
        check_val("fetch_hold", fetch_hold, 0);
        check_val("ds_fwd", ds_fwd, 0);
        check_val("es_fwd", es_fwd, 0);
        check_val("stall_d", stall_d, 0);
        check_val("stall_e", stall_e, 0);
        check_val("retire.valid", retire.valid, 0);
        @(posedge clk);
        #1;

        for (int i = 0; i < n_rows && !hung; i++) begin
            apply_row(i, hung);
        end
        fs_desc = '0;
        cur_row = -1;

        if (!hung) begin
            tries = 0;
            while (retired < n_valid && tries < DRAIN_LIMIT) begin
                @(posedge clk);
                tries++;
            end
            if (retired < n_valid) begin
                $display("timeout: only %0d of %0d instructions retired", retired, n_valid);
                errors++;
            end
            if (ret_q.size() != 0) begin
                $display("accepted instructions left without retiring");
                errors++;
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- tb/pipe_ctrl_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic [1:0] stall_d,
    input logic [1:0] stall_e,
    input logic       fetch_hold,
    input logic [3:0] ds_fwd,
    input logic [3:0] es_fwd
);

    // flush code and 11 never produced
    stall_code_legal: assert property (@(posedge clk) disable iff (!rst_n)
        !stall_d[1] && !stall_e[1])
        else $error("stall code outside normal/stall");

    fwd_sel_legal: assert property (@(posedge clk) disable iff (!rst_n)
        ds_fwd[3:2] != 2'b11 && ds_fwd[1:0] != 2'b11
        && es_fwd[3:2] != 2'b11 && es_fwd[1:0] != 2'b11)
        else $error("forward select equals 11");

    // execute stall must freeze fetch too
    stall_e_holds_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        stall_e == 2'b01 |-> fetch_hold)
        else $error("stall_e without fetch_hold");

endmodule

`default_nettype wire

//--- logic/pipe_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  pipe_ctrl_pkg::inst_desc_t  fs_desc,
    output logic                       fetch_hold,
    output logic [3:0]                 ds_fwd,
    output logic [3:0]                 es_fwd,
    output pipe_ctrl_pkg::stall_code_t stall_d,
    output pipe_ctrl_pkg::stall_code_t stall_e,
    output pipe_ctrl_pkg::stage_info_t retire,
    output pipe_ctrl_pkg::inst_id_t    retire_id
);

    import pipe_ctrl_pkg::*;

    inst_desc_t  d_desc;
    inst_desc_t  e_desc;
    stage_info_t m_info;
    stage_info_t w_info;
    logic        e_new;
    logic        div_stop;

    stage_regs stage_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .fs_desc   (fs_desc),
        .stall_d   (stall_d),
        .stall_e   (stall_e),
        .d_desc    (d_desc),
        .e_desc    (e_desc),
        .e_new     (e_new),
        .m_info    (m_info),
        .w_info    (w_info),
        .retire_id (retire_id)
    );

    div_busy div_busy_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .e_desc   (e_desc),
        .e_new    (e_new),
        .div_stop (div_stop)
    );

    hazard_unit hazard_unit_i (
        .d_desc     (d_desc),
        .e_desc     (e_desc),
        .m_info     (m_info),
        .w_info     (w_info),
        .div_stop   (div_stop),
        .stall_d    (stall_d),
        .stall_e    (stall_e),
        .fetch_hold (fetch_hold),
        .ds_fwd     (ds_fwd),
        .es_fwd     (es_fwd)
    );

    // writeback contents are what retires
    assign retire = w_info;

endmodule

`default_nettype wire

//--- logic/div_busy.sv
`timescale 1ns/1ns
`default_nettype none

module div_busy (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pipe_ctrl_pkg::inst_desc_t e_desc,
    input  logic                      e_new,
    output logic                      div_stop
);

    import pipe_ctrl_pkg::*;

    logic [DIV_CNT_W-1:0] cnt;
    logic                 start;

    // first execute cycle of a divide
    assign start = e_new && e_desc.valid && e_desc.is_div;

    // high on the start cycle plus DIV_CYCLES-2 counted ones
    assign div_stop = start || (cnt != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= DIV_CNT_W'(DIV_CYCLES - 2);
        end else if (e_new) begin
            // execute got something else, drop any leftover count
            cnt <= '0;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/stage_regs.sv
`timescale 1ns/1ns
`default_nettype none

module stage_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  pipe_ctrl_pkg::inst_desc_t  fs_desc,
    input  pipe_ctrl_pkg::stall_code_t stall_d,
    input  pipe_ctrl_pkg::stall_code_t stall_e,
    output pipe_ctrl_pkg::inst_desc_t  d_desc,
    output pipe_ctrl_pkg::inst_desc_t  e_desc,
    output logic                       e_new,
    output pipe_ctrl_pkg::stage_info_t m_info,
    output pipe_ctrl_pkg::stage_info_t w_info,
    output pipe_ctrl_pkg::inst_id_t    retire_id
);

    import pipe_ctrl_pkg::*;

    inst_desc_t  d_q;
    inst_desc_t  e_q;
    stage_info_t m_q;
    stage_info_t w_q;
    inst_id_t    m_id;
    inst_id_t    w_id;
    logic        d_hold;
    logic        e_hold;
    logic        e_bubble;

    // an empty decode slot still takes the next instruction under stall_d
    assign d_hold   = (stall_e == st_stall) || (stall_d == st_stall && d_q.valid);
    assign e_hold   = (stall_e == st_stall);
    assign e_bubble = (stall_d == st_stall);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_q <= '0;
        end else if (!d_hold) begin
            d_q <= fs_desc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_q   <= '0;
            e_new <= 1'b0;
        end else begin
            e_new <= !e_hold;
            if (!e_hold) begin
                if (e_bubble) begin
                    e_q <= '0;
                end else begin
                    e_q <= d_q;
                end
            end
        end
    end

    // memory takes a bubble while execute is held
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_q  <= '0;
            m_id <= '0;
        end else begin
            m_id <= e_q.id;
            if (e_hold) begin
                m_q <= '0;
            end else begin
                m_q <= desc_info(e_q);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_q  <= '0;
            w_id <= '0;
        end else begin
            w_q  <= m_q;
            w_id <= m_id;
        end
    end

    assign d_desc    = d_q;
    assign e_desc    = e_q;
    assign m_info    = m_q;
    assign w_info    = w_q;
    assign retire_id = w_id;

endmodule

`default_nettype wire

//--- hazard/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  pipe_ctrl_pkg::inst_desc_t  d_desc,
    input  pipe_ctrl_pkg::inst_desc_t  e_desc,
    input  pipe_ctrl_pkg::stage_info_t m_info,
    input  pipe_ctrl_pkg::stage_info_t w_info,
    input  logic                       div_stop,
    output pipe_ctrl_pkg::stall_code_t stall_d,
    output pipe_ctrl_pkg::stall_code_t stall_e,
    output logic                       fetch_hold,
    output logic [3:0]                 ds_fwd,
    output logic [3:0]                 es_fwd
);

    import pipe_ctrl_pkg::*;

    stage_info_t e_info;
    fwd_sel_t    ds_sel1;
    fwd_sel_t    ds_sel2;
    fwd_sel_t    es_sel1;
    fwd_sel_t    es_sel2;
    logic        br_load_use;
    logic        mfc0_pend;

    assign e_info = desc_info(e_desc);

    // branch resolves in decode, so a load result one stage ahead is too late
    // r0 is not excluded here
    assign br_load_use = d_desc.valid && d_desc.is_branch
                      && e_desc.valid && e_desc.gr_we && e_desc.res_from_mem
                      && (d_desc.raddr1 == e_desc.dest || d_desc.raddr2 == e_desc.dest);

    // cp0 read not yet back
    assign mfc0_pend = (e_info.valid && e_info.res_from_cp0)
                    || (m_info.valid && m_info.res_from_cp0);

    // priority: branch-load-use, divider, mfc0
    always_comb begin
        stall_d = st_normal;
        stall_e = st_normal;
        if (br_load_use) begin
            stall_d = st_stall;
        end else if (div_stop) begin
            stall_e = st_stall;
        end else if (mfc0_pend) begin
            stall_d = st_stall;
        end
    end

    assign fetch_hold = (stall_d == st_stall && d_desc.valid) || (stall_e == st_stall);

    // decode operands: execute is near, memory is far
    fwd_select ds_fwd_i (
        .src1 (d_desc.raddr1),
        .src2 (d_desc.raddr2),
        .near (e_info),
        .far  (m_info),
        .sel1 (ds_sel1),
        .sel2 (ds_sel2)
    );

    // execute operands: memory is near, writeback is far
    fwd_select es_fwd_i (
        .src1 (e_desc.raddr1),
        .src2 (e_desc.raddr2),
        .near (m_info),
        .far  (w_info),
        .sel1 (es_sel1),
        .sel2 (es_sel2)
    );

    // operand 1 in the upper pair
    assign ds_fwd = {ds_sel1, ds_sel2};
    assign es_fwd = {es_sel1, es_sel2};

endmodule

`default_nettype wire

//--- hazard/fwd_select.sv
`timescale 1ns/1ns
`default_nettype none

module fwd_select (
    input  pipe_ctrl_pkg::reg_addr_t   src1,
    input  pipe_ctrl_pkg::reg_addr_t   src2,
    input  pipe_ctrl_pkg::stage_info_t near,
    input  pipe_ctrl_pkg::stage_info_t far,
    output pipe_ctrl_pkg::fwd_sel_t    sel1,
    output pipe_ctrl_pkg::fwd_sel_t    sel2
);

    import pipe_ctrl_pkg::*;

    // nearer stage wins, r0 never forwards
    function automatic fwd_sel_t pick(reg_addr_t src, stage_info_t n, stage_info_t f);
        fwd_sel_t sel;
        sel = fwd_rf;
        if (src != '0) begin
            if (n.valid && n.gr_we && n.dest == src) begin
                sel = fwd_near;
            end else if (f.valid && f.gr_we && f.dest == src) begin
                sel = fwd_far;
            end
        end
        return sel;
    endfunction

    always_comb begin
        sel1 = pick(src1, near, far);
        sel2 = pick(src2, near, far);
    end

endmodule

`default_nettype wire

//--- common/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

    localparam int DIV_CYCLES = 4;
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);

    typedef logic [4:0] reg_addr_t;
    typedef logic [7:0] inst_id_t;

    // forwarding source for one operand
    typedef enum logic [1:0] {
        fwd_rf   = 2'b00,
        fwd_near = 2'b01,
        fwd_far  = 2'b10
    } fwd_sel_t;

    // 2'b10 kept free for flush
    typedef enum logic [1:0] {
        st_normal = 2'b00,
        st_stall  = 2'b01
    } stall_code_t;

    typedef struct packed {
        logic      valid;
        inst_id_t  id;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        reg_addr_t dest;
        logic      gr_we;
        logic      res_from_mem;
        logic      res_from_cp0;
        logic      is_branch;
        logic      is_div;
    } inst_desc_t;

    // what the hazard checks need from a later stage
    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        logic      gr_we;
        logic      res_from_mem;
        logic      res_from_cp0;
    } stage_info_t;

    function automatic stage_info_t desc_info(inst_desc_t d);
        stage_info_t s;
        s.valid        = d.valid;
        s.dest         = d.dest;
        s.gr_we        = d.gr_we;
        s.res_from_mem = d.res_from_mem;
        s.res_from_cp0 = d.res_from_cp0;
        return s;
    endfunction

endpackage

`default_nettype wire
